// File: mem_sys_pkg.sv
// ==============================
// Shared types and constants for the memory system
// Holds the address map, register offsets and the packed
// bus structs used between the masters, arbiter, sequencer
// and SDRAM port. Import with a wildcard where needed
// ==============================

package mem_sys_pkg;

    // Address map, one base word per region
    localparam logic [31:0] RAM_BASE    = 32'h0000_0000;
    localparam logic [31:0] SDRAM_BASE  = 32'h1000_0000;
    localparam logic [31:0] SYSREG_BASE = 32'h4000_0000;

    // System register offsets within the SYSREG block
    localparam logic [31:0] REG_STATUS   = 32'h0000_0000;
    localparam logic [31:0] REG_CYCLE_LO = 32'h0000_0004;
    localparam logic [31:0] REG_CYCLE_HI = 32'h0000_0008;

    // One Wishbone master request, valid is cyc and stb together
    typedef struct packed {
        logic        valid;
        logic        we;
        logic [29:0] adr;
        logic [31:0] wdata;
        logic [3:0]  sel;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] rdata;
    } wb_rsp_t;

    // Arbitrated request, src is 1 for the data bus
    typedef struct packed {
        logic        valid;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        src;
    } mem_req_t;

    typedef struct packed {
        logic        rd;
        logic        wr;
        logic [23:0] addr;
        logic [31:0] wdata;
    } sdram_cmd_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        busy;
        logic        rdata_valid;
    } sdram_rsp_t;

endpackage

// File: bus_arbiter.sv
// ==============================
// Fixed-priority merge of the instruction and data buses
// The data bus wins whenever it is pending. A request
// counts as pending only while its own ack is low
// ==============================

`timescale 1ns/1ps

module bus_arbiter import mem_sys_pkg::*; (
    input  wb_req_t  ibus_req,
    input  wb_req_t  dbus_req,
    input  logic     ibus_ack,
    input  logic     dbus_ack,
    output mem_req_t mem_req
);

    logic    ibus_pend;
    logic    dbus_pend;
    wb_req_t chosen;

    always_comb begin
        // Mask each request by its own ack
        ibus_pend = ibus_req.valid && !ibus_ack;
        dbus_pend = dbus_req.valid && !dbus_ack;

        chosen = dbus_pend ? dbus_req : ibus_req;

        mem_req.valid = dbus_pend || ibus_pend;
        mem_req.write = chosen.we;
        mem_req.addr  = {chosen.adr, 2'b00};
        mem_req.wdata = chosen.wdata;
        // Strobe stays zero for reads
        mem_req.wstrb = chosen.we ? chosen.sel : 4'b0000;
        mem_req.src   = dbus_pend;
    end

    // Source bit and issued payload must name the same master
    always_comb begin
        assert (!mem_req.src || (mem_req.addr[31:2] == dbus_req.adr
                                 && mem_req.write == dbus_req.we))
            else $error("bus_arbiter: data bus flagged but its request was not issued");
    end

endmodule

// File: block_ram.sv
// ==============================
// Single-port word RAM with byte-enable writes
// Read is registered and returns the new word on a write
// ==============================

`timescale 1ns/1ps

module block_ram #(
    parameter  int RAM_WORDS = 16384,
    localparam int AW        = $clog2(RAM_WORDS)
) (
    input  logic          clk,
    input  logic [AW-1:0] addr,
    input  logic [31:0]   wdata,
    input  logic [3:0]    wstrb,
    input  logic          wren,
    output logic [31:0]   rdata
);

    logic [31:0] mem [RAM_WORDS];
    logic [31:0] merged;

    // Word as it looks after this cycle's write
    always_comb begin
        merged = mem[addr];
        for (int b = 0; b < 4; b++) begin
            if (wren && wstrb[b]) begin
                merged[8*b +: 8] = wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        // Each strobed lane is written on its own
        for (int b = 0; b < 4; b++) begin
            if (wren && wstrb[b]) begin
                mem[addr][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
        rdata <= merged;
    end

endmodule

// File: sys_regs.sv
// ==============================
// System status and cycle counter registers
// load_done arrives from another clock domain and goes
// through a three-stage synchroniser. Read is combinational
// on the word offset driven by the access sequencer
// ==============================

`timescale 1ns/1ps

module sys_regs import mem_sys_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        load_done,
    input  logic [7:0]  offset,
    output logic [31:0] rdata
);

    logic [2:0]  load_sync;
    logic        load_done_s;
    logic [63:0] cycle_count;

    // ==============================
    // Synchroniser and counter
    // ==============================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            load_sync <= 3'b000;
        end else begin
            load_sync <= {load_sync[1:0], load_done};
        end
    end

    assign load_done_s = load_sync[2];

    // Free running, cleared only by reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cycle_count <= 64'd0;
        end else begin
            cycle_count <= cycle_count + 64'd1;
        end
    end

    // ==============================
    // Read decode
    // ==============================

    always_comb begin
        case (offset)
            REG_STATUS[7:0]:   rdata = {30'd0, load_done_s, 1'b1};
            REG_CYCLE_LO[7:0]: rdata = cycle_count[31:0];
            REG_CYCLE_HI[7:0]: rdata = cycle_count[63:32];
            default:           rdata = 32'd0;
        endcase
    end

endmodule

// File: access_sequencer.sv
// ==============================
// Single-access sequencer behind the bus arbiter
// Decodes each accepted request to RAM, SDRAM, system
// registers or the unmapped default, waits for that target
// and pulses the ack of the master that issued it
// ==============================

`timescale 1ns/1ps

module access_sequencer import mem_sys_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  mem_req_t    mem_req,
    output logic [13:0] ram_addr,
    output logic [31:0] ram_wdata,
    output logic [3:0]  ram_wstrb,
    output logic        ram_wren,
    input  logic [31:0] ram_rdata,
    output logic [7:0]  reg_offset,
    input  logic [31:0] reg_rdata,
    output sdram_cmd_t  sdram_cmd,
    input  sdram_rsp_t  sdram_rsp,
    output wb_rsp_t     ibus_rsp,
    output wb_rsp_t     dbus_rsp
);

    typedef enum logic [1:0] {T_RAM, T_SDRAM, T_SYSREG, T_NONE} target_e;
    typedef enum logic [1:0] {S_IDLE, S_STEP, S_FINISH, S_SDRAM} state_e;

    state_e      state;
    target_e     target;
    target_e     req_target;
    logic        accept;
    logic        src_dbus;
    logic        busy_seen;
    logic        sd_rd;
    logic        sd_wr;
    logic        ibus_ack;
    logic        dbus_ack;
    logic        done;
    logic [31:0] done_data;

    // Captured request payload
    logic [31:0] addr_q;
    logic [31:0] wdata_q;
    logic [3:0]  wstrb_q;
    logic        write_q;
    logic [31:0] rsp_data;

    // ==============================
    // Decode and completion
    // ==============================

    always_comb begin
        if (mem_req.addr[31:16] == RAM_BASE[31:16]) begin
            req_target = T_RAM;
        end else if (mem_req.addr[31:26] == SDRAM_BASE[31:26]) begin
            req_target = T_SDRAM;
        end else if (mem_req.addr[31:8] == SYSREG_BASE[31:8]) begin
            req_target = T_SYSREG;
        end else begin
            req_target = T_NONE;
        end
    end

    assign accept = (state == S_IDLE) && mem_req.valid;

    always_comb begin
        done      = 1'b0;
        done_data = 32'd0;
        case (state)
            // Unmapped finishes one edge after acceptance with zero
            S_STEP: done = (target == T_NONE);
            S_FINISH: begin
                done      = 1'b1;
                done_data = (target == T_RAM) ? ram_rdata : reg_rdata;
            end
            S_SDRAM: begin
                if (write_q) begin
                    done = busy_seen && !sdram_rsp.busy;
                end else begin
                    done      = sdram_rsp.rdata_valid;
                    done_data = sdram_rsp.rdata;
                end
            end
            default: done = 1'b0;
        endcase
    end

    // ==============================
    // Control state
    // ==============================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= S_IDLE;
            target    <= T_NONE;
            src_dbus  <= 1'b0;
            busy_seen <= 1'b0;
            sd_rd     <= 1'b0;
            sd_wr     <= 1'b0;
            ibus_ack  <= 1'b0;
            dbus_ack  <= 1'b0;
        end else begin
            sd_rd    <= 1'b0;
            sd_wr    <= 1'b0;
            ibus_ack <= done && !src_dbus;
            dbus_ack <= done && src_dbus;

            if (accept) begin
                target   <= req_target;
                src_dbus <= mem_req.src;
                if (req_target == T_SDRAM) begin
                    sd_rd     <= !mem_req.write;
                    sd_wr     <= mem_req.write;
                    busy_seen <= 1'b0;
                    state     <= S_SDRAM;
                end else begin
                    state <= S_STEP;
                end
            end else if (done) begin
                state <= S_IDLE;
            end else if (state == S_STEP) begin
                // RAM and register accesses take one wait state
                state <= S_FINISH;
            end else if (state == S_SDRAM && sdram_rsp.busy) begin
                busy_seen <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= mem_req.addr;
            wdata_q <= mem_req.wdata;
            wstrb_q <= mem_req.wstrb;
            write_q <= mem_req.write;
        end
        if (done) begin
            rsp_data <= done_data;
        end
    end

    // ==============================
    // Target and master outputs
    // ==============================

    assign ram_addr   = addr_q[15:2];
    assign ram_wdata  = wdata_q;
    assign ram_wstrb  = wstrb_q;
    // RAM access happens in the cycle after acceptance
    assign ram_wren   = (state == S_STEP) && (target == T_RAM) && write_q;
    assign reg_offset = addr_q[7:0];

    assign sdram_cmd = '{rd: sd_rd, wr: sd_wr, addr: addr_q[25:2], wdata: wdata_q};

    assign ibus_rsp = '{ack: ibus_ack, rdata: rsp_data};
    assign dbus_rsp = '{ack: dbus_ack, rdata: rsp_data};

    a_one_ack: assert property (@(posedge clk) disable iff (reset)
        !(ibus_rsp.ack && dbus_rsp.ack));

    a_one_cmd: assert property (@(posedge clk) disable iff (reset)
        !(sdram_cmd.rd && sdram_cmd.wr));

endmodule

// File: mem_system.sv
// ==============================
// Memory system top level
// Two Wishbone masters share one access path to the
// on-chip RAM, the external SDRAM port and the system
// registers. RAM_WORDS sizes the RAM inside the 64 KB window
// ==============================

`timescale 1ns/1ps

module mem_system import mem_sys_pkg::*; #(
    parameter int RAM_WORDS = 16384
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       load_done,
    input  wb_req_t    ibus_req,
    input  wb_req_t    dbus_req,
    output wb_rsp_t    ibus_rsp,
    output wb_rsp_t    dbus_rsp,
    output sdram_cmd_t sdram_cmd,
    input  sdram_rsp_t sdram_rsp
);

    localparam int RAM_AW = $clog2(RAM_WORDS);

    mem_req_t    mem_req;
    logic [13:0] ram_addr;
    logic [31:0] ram_wdata;
    logic [3:0]  ram_wstrb;
    logic        ram_wren;
    logic [31:0] ram_rdata;
    logic [7:0]  reg_offset;
    logic [31:0] reg_rdata;

    bus_arbiter u_arbiter (
        .ibus_req (ibus_req),
        .dbus_req (dbus_req),
        .ibus_ack (ibus_rsp.ack),
        .dbus_ack (dbus_rsp.ack),
        .mem_req  (mem_req)
    );

    access_sequencer u_sequencer (
        .clk        (clk),
        .reset      (reset),
        .mem_req    (mem_req),
        .ram_addr   (ram_addr),
        .ram_wdata  (ram_wdata),
        .ram_wstrb  (ram_wstrb),
        .ram_wren   (ram_wren),
        .ram_rdata  (ram_rdata),
        .reg_offset (reg_offset),
        .reg_rdata  (reg_rdata),
        .sdram_cmd  (sdram_cmd),
        .sdram_rsp  (sdram_rsp),
        .ibus_rsp   (ibus_rsp),
        .dbus_rsp   (dbus_rsp)
    );

    // Smaller RAMs alias inside the RAM window
    block_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) u_ram (
        .clk   (clk),
        .addr  (ram_addr[RAM_AW-1:0]),
        .wdata (ram_wdata),
        .wstrb (ram_wstrb),
        .wren  (ram_wren),
        .rdata (ram_rdata)
    );

    sys_regs u_regs (
        .clk       (clk),
        .reset     (reset),
        .load_done (load_done),
        .offset    (reg_offset),
        .rdata     (reg_rdata)
    );

endmodule

// File: tb_clock.sv
// ==============================
// Testbench clock and reset source
// Free running clock, reset held high for a few cycles
// ==============================

`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD_NS    = 4.0,
    parameter int  RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // Released on a falling edge, away from the active edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// File: tb_sdram_model.sv
// ==============================
// Behavioural SDRAM word port for the testbench
// Takes one rd or wr pulse at a time and finishes it after
// a latency of 1 to 8 cycles drawn from an LCG
// ==============================

`timescale 1ns/1ps

module tb_sdram_model import mem_sys_pkg::*; #(
    parameter logic [31:0] SEED = 32'd63070
) (
    input  logic       clk,
    input  logic       reset,
    input  sdram_cmd_t sdram_cmd,
    output sdram_rsp_t sdram_rsp
);

    logic [31:0] mem [logic [23:0]];
    logic [31:0] lcg_state;
    logic [7:0]  count;
    logic        reading;
    logic [31:0] held_data;
    logic        busy_q;
    logic        valid_q;
    logic [31:0] rdata_q;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Unwritten words read back as a pattern of their full address
    function automatic logic [31:0] word_at(input logic [23:0] a);
        return mem.exists(a) ? mem[a] : {8'hC3, a};
    endfunction

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            lcg_state <= SEED;
            count     <= 8'd0;
            reading   <= 1'b0;
            held_data <= 32'd0;
            busy_q    <= 1'b0;
            valid_q   <= 1'b0;
            rdata_q   <= 32'd0;
        end else begin
            valid_q <= 1'b0;
            if (sdram_cmd.rd || sdram_cmd.wr) begin
                // Upper LCG bits give the latency
                count     <= 8'd1 + {5'd0, lcg_state[30:28]};
                lcg_state <= lcg_next(lcg_state);
                reading   <= sdram_cmd.rd;
                if (sdram_cmd.rd) begin
                    held_data <= word_at(sdram_cmd.addr);
                end else begin
                    mem[sdram_cmd.addr] = sdram_cmd.wdata;
                    busy_q <= 1'b1;
                end
            end else if (count != 8'd0) begin
                count <= count - 8'd1;
                if (count == 8'd1) begin
                    if (reading) begin
                        valid_q <= 1'b1;
                        rdata_q <= held_data;
                    end else begin
                        busy_q <= 1'b0;
                    end
                end
            end
        end
    end

    assign sdram_rsp = '{rdata: rdata_q, busy: busy_q, rdata_valid: valid_q};

endmodule

// File: tb_mem_system.sv
// ==============================
// Directed testbench for the memory system
// Drives both Wishbone masters on the falling edge and
// checks RAM, SDRAM, system register, unmapped and
// arbitration behaviour against the address map rules
// ==============================

`timescale 1ns/1ps

module tb_mem_system import mem_sys_pkg::*; ();

    localparam int          RAM_WORDS = 16384;
    localparam int          TIMEOUT   = 200;
    localparam logic [31:0] SEED      = 32'd63070;

    logic       clk;
    logic       reset;
    logic       load_done;
    wb_req_t    ibus_req;
    wb_req_t    dbus_req;
    wb_rsp_t    ibus_rsp;
    wb_rsp_t    dbus_rsp;
    sdram_cmd_t sdram_cmd;
    sdram_rsp_t sdram_rsp;

    logic [31:0] rand_state;

    tb_clock #(.PERIOD_NS(4.0), .RESET_CYCLES(2)) u_clock (.clk(clk), .reset(reset));

    tb_sdram_model #(.SEED(SEED)) u_sdram (
        .clk       (clk),
        .reset     (reset),
        .sdram_cmd (sdram_cmd),
        .sdram_rsp (sdram_rsp)
    );

    mem_system #(.RAM_WORDS(RAM_WORDS)) uut (
        .clk       (clk),
        .reset     (reset),
        .load_done (load_done),
        .ibus_req  (ibus_req),
        .dbus_req  (dbus_req),
        .ibus_rsp  (ibus_rsp),
        .dbus_rsp  (dbus_rsp),
        .sdram_cmd (sdram_cmd),
        .sdram_rsp (sdram_rsp)
    );

    // ==============================
    // Helpers
    // ==============================

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            fail_run($sformatf("error at time %0t: %s gave %h, expected %h",
                               $time, what, got, expected));
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Byte lane merge as a strobed write should leave the word
    function automatic logic [31:0] apply_strobe(input logic [31:0] old,
                                                 input logic [31:0] wdata,
                                                 input logic [3:0] sel);
        logic [31:0] result;
        result = old;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                result[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return result;
    endfunction

    function automatic wb_req_t make_req(input logic write, input logic [31:0] addr,
                                         input logic [31:0] wdata, input logic [3:0] sel);
        wb_req_t req;
        req.valid = 1'b1;
        req.we    = write;
        req.adr   = addr[31:2];
        req.wdata = wdata;
        req.sel   = sel;
        return req;
    endfunction

    task automatic wait_for_reset();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (reset && cycles >= 20) begin
                fail_run("reset was never released");
            end
        end while (reset);
    endtask

    // One access on either master; cycles counts falling edges up to the ack
    task automatic bus_access(input logic use_dbus, input logic write,
                              input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] sel, output logic [31:0] rdata,
                              output int cycles);
        logic got_ack;
        got_ack = 1'b0;
        cycles  = 0;
        @(negedge clk);
        if (use_dbus) begin
            dbus_req = make_req(write, addr, wdata, sel);
        end else begin
            ibus_req = make_req(write, addr, wdata, sel);
        end
        while (!got_ack) begin
            @(negedge clk);
            cycles++;
            got_ack = use_dbus ? dbus_rsp.ack : ibus_rsp.ack;
            if (!got_ack && cycles >= TIMEOUT) begin
                fail_run($sformatf("no ack within %0d cycles for the access at %h",
                                   TIMEOUT, addr));
            end
        end
        rdata = use_dbus ? dbus_rsp.rdata : ibus_rsp.rdata;
        // Dropped in the ack cycle so the request is not taken twice
        if (use_dbus) begin
            dbus_req.valid = 1'b0;
        end else begin
            ibus_req.valid = 1'b0;
        end
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] sel);
        logic [31:0] unused_data;
        int          cycles;
        bus_access(1'b1, 1'b1, addr, wdata, sel, unused_data, cycles);
    endtask

    task automatic read_word(input logic use_dbus, input logic [31:0] addr,
                             output logic [31:0] rdata, output int cycles);
        bus_access(use_dbus, 1'b0, addr, 32'd0, 4'h0, rdata, cycles);
    endtask

    // ==============================
    // Directed tests
    // ==============================

    task automatic reset_outputs_low();
        check_value("acks and SDRAM commands after reset",
                    {28'd0, ibus_rsp.ack, dbus_rsp.ack, sdram_cmd.rd, sdram_cmd.wr}, 32'd0);
    endtask

    task automatic ram_byte_writes();
        logic [31:0] expected;
        logic [31:0] data;
        int          cycles;
        expected = apply_strobe(32'd0, 32'h1122_3344, 4'hF);
        write_word(RAM_BASE + 32'h100, 32'h1122_3344, 4'hF);
        write_word(RAM_BASE + 32'h100, 32'h0000_AA00, 4'b0010);
        expected = apply_strobe(expected, 32'h0000_AA00, 4'b0010);
        write_word(RAM_BASE + 32'h100, 32'hBB00_0000, 4'b1000);
        expected = apply_strobe(expected, 32'hBB00_0000, 4'b1000);
        read_word(1'b1, RAM_BASE + 32'h100, data, cycles);
        check_value("RAM merged word", data, expected);
        // Drive edge, acceptance edge, two more edges to the ack
        check_value("RAM read ack latency", cycles, 32'd3);
    endtask

    task automatic sdram_round_trip();
        logic [31:0] addrs   [6];
        logic [31:0] written [6];
        logic [31:0] data;
        int          cycles;
        for (int i = 0; i < 6; i++) begin
            addrs[i]   = SDRAM_BASE | ((i * 32'h0013_5794) & 32'h03FF_FFFC);
            rand_state = lcg_next(rand_state);
            written[i] = rand_state;
            write_word(addrs[i], written[i], 4'hF);
        end
        // Odd entries come back over the instruction bus
        for (int i = 0; i < 6; i++) begin
            read_word((i % 2) == 0, addrs[i], data, cycles);
            check_value($sformatf("SDRAM word at %h", addrs[i]), data, written[i]);
        end
    endtask

    task automatic sys_reg_reads();
        logic [31:0] status;
        logic [31:0] first;
        logic [31:0] second;
        int          cycles;
        int          tries;
        read_word(1'b1, SYSREG_BASE + REG_STATUS, status, cycles);
        check_value("status before load_done", status, 32'd1);
        @(negedge clk);
        load_done = 1'b1;
        tries = 0;
        status = 32'd0;
        while (status != 32'd3) begin
            read_word(1'b1, SYSREG_BASE + REG_STATUS, status, cycles);
            tries++;
            if (status != 32'd3 && tries >= 8) begin
                fail_run("status never showed load_done after it was raised");
            end
        end
        read_word(1'b1, SYSREG_BASE + REG_CYCLE_LO, first, cycles);
        read_word(1'b1, SYSREG_BASE + REG_CYCLE_LO, second, cycles);
        check_value("cycle low word increasing", {31'd0, second > first}, 32'd1);
        read_word(1'b1, SYSREG_BASE + REG_CYCLE_HI, second, cycles);
        check_value("cycle high word", second, 32'd0);
    endtask

    task automatic unmapped_reads();
        logic [31:0] data;
        int          cycles;
        // A nonzero word goes out first so each zero below is fresh
        read_word(1'b1, SYSREG_BASE + REG_STATUS, data, cycles);
        check_value("status before unmapped read", data, 32'd3);
        read_word(1'b1, 32'h2000_0000, data, cycles);
        check_value("unmapped read data", data, 32'd0);
        check_value("unmapped ack latency", cycles, 32'd2);
        read_word(1'b0, SYSREG_BASE + REG_STATUS, data, cycles);
        check_value("status before unused register read", data, 32'd3);
        read_word(1'b0, SYSREG_BASE + 32'h0C, data, cycles);
        check_value("unused system register", data, 32'd0);
    endtask

    task automatic arbitration_order();
        logic [31:0] iword;
        logic [31:0] dword;
        logic        i_done;
        logic        d_done;
        logic        d_first;
        int          cycles;
        write_word(RAM_BASE + 32'h200, 32'hCAFE_0001, 4'hF);
        write_word(RAM_BASE + 32'h204, 32'hBEEF_0002, 4'hF);
        i_done  = 1'b0;
        d_done  = 1'b0;
        d_first = 1'b0;
        cycles  = 0;
        @(negedge clk);
        ibus_req = make_req(1'b0, RAM_BASE + 32'h200, 32'd0, 4'h0);
        dbus_req = make_req(1'b0, RAM_BASE + 32'h204, 32'd0, 4'h0);
        while (!(i_done && d_done)) begin
            @(negedge clk);
            cycles++;
            if (dbus_rsp.ack && !d_done) begin
                d_done         = 1'b1;
                d_first        = !i_done;
                dword          = dbus_rsp.rdata;
                dbus_req.valid = 1'b0;
            end
            if (ibus_rsp.ack && !i_done) begin
                i_done         = 1'b1;
                iword          = ibus_rsp.rdata;
                ibus_req.valid = 1'b0;
            end
            if (!(i_done && d_done) && cycles >= TIMEOUT) begin
                fail_run("both masters were not acked in the arbitration test");
            end
        end
        check_value("data bus acked first", {31'd0, d_first}, 32'd1);
        check_value("data bus word", dword, 32'hBEEF_0002);
        check_value("instruction bus word", iword, 32'hCAFE_0001);
    endtask

    // ==============================
    // Test sequence
    // ==============================

    initial begin
        ibus_req   = '0;
        dbus_req   = '0;
        load_done  = 1'b0;
        rand_state = SEED;
        wait_for_reset();
        reset_outputs_low();
        ram_byte_writes();
        sdram_round_trip();
        sys_reg_reads();
        unmapped_reads();
        arbitration_order();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: all.f
mem_sys_pkg.sv
bus_arbiter.sv
block_ram.sv
sys_regs.sv
access_sequencer.sv
mem_system.sv
tb_clock.sv
tb_sdram_model.sv
tb_mem_system.sv

// File: Makefile
# Verilator build and run for the memory system testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_system
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= TESTS PASSED

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
